/* Bender.yml */
package:
  name: fpu_pipe

sources:
  - include_dirs:
      - .
    files:
      - fpu_pkg.sv
      - fpu_decode.sv
      - fpu_regfile.sv
      - fpu_exec.sv
      - fpu_pipe_ctrl.sv
      - fpu_pipe.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - fpu_tb.sv

/* fpu_cfg.svh */
`ifndef FPU_CFG_SVH
`define FPU_CFG_SVH

// Register file geometry
`define FPU_NREGS        32
`define FPU_AW           5
`define FPU_DW           32

// Major opcodes
`define FPU_OPC_OPFP     7'b1010011
`define FPU_OPC_LOADFP   7'b0000111
`define FPU_OPC_SYSTEM   7'b1110011

// funct7 groups inside OP-FP, single precision only
`define FPU_F7_SGNJ      7'b0010000
`define FPU_F7_MINMAX    7'b0010100
`define FPU_F7_CMP       7'b1010000
`define FPU_F7_MVXW      7'b1110000
`define FPU_F7_MVWX      7'b1111000

`define FPU_F3_LW        3'b010
`define FPU_F3_CSRRW     3'b001
`define FPU_CSR_FFLAGS   12'h001

// Operand source selects into EXE
`define FPU_FWD_RF       2'd0
`define FPU_FWD_MEM      2'd1
`define FPU_FWD_WB       2'd2

`endif

/* fpu_decode.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_decode
(
   input  wire logic [31:0]      instr_i,
   output fpu_pkg::fpu_decode_s  dec_o
);

   logic [6:0]       opcode;
   logic [6:0]       funct7;
   logic [2:0]       funct3;
   fpu_pkg::fpu_op_e op;

   assign opcode = instr_i[6:0];
   assign funct3 = instr_i[14:12];
   assign funct7 = instr_i[31:25];

   always_comb
   begin
      op = fpu_pkg::OP_NONE;
      case (opcode)
         `FPU_OPC_LOADFP:
         begin
            if (funct3 == `FPU_F3_LW)
               op = fpu_pkg::OP_FLW;
         end
         `FPU_OPC_SYSTEM:
         begin
            if (funct3 == `FPU_F3_CSRRW && instr_i[31:20] == `FPU_CSR_FFLAGS)
               op = fpu_pkg::OP_CSRRW;
         end
         `FPU_OPC_OPFP:
         begin
            case (funct7)
               `FPU_F7_SGNJ:
                  case (funct3)
                     3'b000: op = fpu_pkg::OP_FSGNJ;
                     3'b001: op = fpu_pkg::OP_FSGNJN;
                     3'b010: op = fpu_pkg::OP_FSGNJX;
                     default: op = fpu_pkg::OP_NONE;
                  endcase
               `FPU_F7_MINMAX:
                  case (funct3)
                     3'b000: op = fpu_pkg::OP_FMIN;
                     3'b001: op = fpu_pkg::OP_FMAX;
                     default: op = fpu_pkg::OP_NONE;
                  endcase
               `FPU_F7_CMP:
                  case (funct3)
                     3'b010: op = fpu_pkg::OP_FEQ;
                     3'b001: op = fpu_pkg::OP_FLT;
                     3'b000: op = fpu_pkg::OP_FLE;
                     default: op = fpu_pkg::OP_NONE;
                  endcase
               // rs2 must be zero for the single-operand forms
               `FPU_F7_MVXW:
               begin
                  if (instr_i[24:20] == 5'd0 && funct3 == 3'b000)
                     op = fpu_pkg::OP_FMVXW;
                  else if (instr_i[24:20] == 5'd0 && funct3 == 3'b001)
                     op = fpu_pkg::OP_FCLASS;
               end
               `FPU_F7_MVWX:
               begin
                  if (instr_i[24:20] == 5'd0 && funct3 == 3'b000)
                     op = fpu_pkg::OP_FMVWX;
               end
               default: op = fpu_pkg::OP_NONE;
            endcase
         end
         default: op = fpu_pkg::OP_NONE;
      endcase
   end

   always_comb
   begin
      dec_o     = '0;
      dec_o.op  = op;
      dec_o.rs1 = instr_i[19:15];
      dec_o.rs2 = instr_i[24:20];
      dec_o.rd  = instr_i[11:7];
      case (op)
         fpu_pkg::OP_FSGNJ, fpu_pkg::OP_FSGNJN, fpu_pkg::OP_FSGNJX:
         begin
            dec_o.reads_frs1 = 1'b1;
            dec_o.reads_frs2 = 1'b1;
            dec_o.writes_frf = 1'b1;
         end
         fpu_pkg::OP_FMIN, fpu_pkg::OP_FMAX:
         begin
            dec_o.reads_frs1    = 1'b1;
            dec_o.reads_frs2    = 1'b1;
            dec_o.writes_frf    = 1'b1;
            dec_o.writes_fflags = 1'b1;
         end
         fpu_pkg::OP_FEQ, fpu_pkg::OP_FLT, fpu_pkg::OP_FLE:
         begin
            dec_o.reads_frs1    = 1'b1;
            dec_o.reads_frs2    = 1'b1;
            dec_o.writes_int    = 1'b1;
            dec_o.writes_fflags = 1'b1;
         end
         fpu_pkg::OP_FCLASS, fpu_pkg::OP_FMVXW:
         begin
            dec_o.reads_frs1 = 1'b1;
            dec_o.writes_int = 1'b1;
         end
         fpu_pkg::OP_FMVWX, fpu_pkg::OP_FLW:
            dec_o.writes_frf = 1'b1;
         fpu_pkg::OP_CSRRW:
         begin
            dec_o.writes_int    = 1'b1;
            dec_o.writes_fflags = 1'b1;
            dec_o.is_csr        = 1'b1;
         end
         default: dec_o.op = fpu_pkg::OP_NONE;
      endcase
   end

endmodule

`default_nettype wire

/* fpu_exec.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_exec
(
   input  wire fpu_pkg::fpu_op_e  op_i,
   input  wire fpu_pkg::fword_t   a_i,
   input  wire fpu_pkg::fword_t   b_i,
   input  wire fpu_pkg::xword_t   xval_i,
   input  wire fpu_pkg::fflags_t  flags_i,
   output fpu_pkg::fword_t        result_o,
   output fpu_pkg::fflags_t       flags_o
);

   localparam fpu_pkg::fword_t CANON_NAN = 32'h7FC0_0000;

   logic       a_exp_max;
   logic       a_exp_zero;
   logic       a_man_zero;
   logic       a_nan, b_nan;
   logic       a_snan, b_snan;
   logic       any_nan, any_snan;
   logic       both_zero;
   logic       ord_lt, ord_eq, tot_lt;
   logic [9:0] cls;

   assign a_exp_max  = &a_i[30:23];
   assign a_exp_zero = ~|a_i[30:23];
   assign a_man_zero = ~|a_i[22:0];
   assign a_nan      = a_exp_max & ~a_man_zero;
   assign b_nan      = (&b_i[30:23]) & (|b_i[22:0]);
   // Quiet bit is the top mantissa bit
   assign a_snan     = a_nan & ~a_i[22];
   assign b_snan     = b_nan & ~b_i[22];
   assign any_nan    = a_nan | b_nan;
   assign any_snan   = a_snan | b_snan;

   // Ordered compare on sign-magnitude words, +0 and -0 equal
   assign both_zero = ~|{a_i[30:0], b_i[30:0]};
   assign ord_eq    = (a_i == b_i) | both_zero;

   always_comb
   begin
      if (a_i[31] != b_i[31])
         ord_lt = a_i[31] & ~both_zero;
      else if (a_i[31])
         ord_lt = a_i[30:0] > b_i[30:0];
      else
         ord_lt = a_i[30:0] < b_i[30:0];
   end

   // Min/max order, where -0 sits below +0
   assign tot_lt = (a_i[31] != b_i[31]) ? a_i[31] : ord_lt;

   always_comb
   begin
      if (a_nan)
         cls = a_i[22] ? 10'b10_0000_0000 : 10'b01_0000_0000;
      else if (a_exp_max)
         cls = a_i[31] ? 10'b00_0000_0001 : 10'b00_1000_0000;
      else if (a_exp_zero && a_man_zero)
         cls = a_i[31] ? 10'b00_0000_1000 : 10'b00_0001_0000;
      else if (a_exp_zero)
         cls = a_i[31] ? 10'b00_0000_0100 : 10'b00_0010_0000;
      else
         cls = a_i[31] ? 10'b00_0000_0010 : 10'b00_0100_0000;
   end

   always_comb
   begin
      result_o = '0;
      flags_o  = '0;
      case (op_i)
         fpu_pkg::OP_FSGNJ:  result_o = {b_i[31], a_i[30:0]};
         fpu_pkg::OP_FSGNJN: result_o = {~b_i[31], a_i[30:0]};
         fpu_pkg::OP_FSGNJX: result_o = {a_i[31] ^ b_i[31], a_i[30:0]};
         fpu_pkg::OP_FMIN, fpu_pkg::OP_FMAX:
         begin
            if (a_nan && b_nan)
               result_o = CANON_NAN;
            else if (a_nan)
               result_o = b_i;
            else if (b_nan)
               result_o = a_i;
            else if (tot_lt ^ (op_i == fpu_pkg::OP_FMAX))
               result_o = a_i;
            else
               result_o = b_i;
            flags_o[4] = any_snan;
         end
         // FEQ is a quiet compare, FLT and FLE signal on any NaN
         fpu_pkg::OP_FEQ:
         begin
            result_o[0] = ~any_nan & ord_eq;
            flags_o[4]  = any_snan;
         end
         fpu_pkg::OP_FLT:
         begin
            result_o[0] = ~any_nan & ord_lt;
            flags_o[4]  = any_nan;
         end
         fpu_pkg::OP_FLE:
         begin
            result_o[0] = ~any_nan & (ord_lt | ord_eq);
            flags_o[4]  = any_nan;
         end
         fpu_pkg::OP_FCLASS: result_o = {22'b0, cls};
         fpu_pkg::OP_FMVXW:  result_o = a_i;
         fpu_pkg::OP_FMVWX, fpu_pkg::OP_FLW: result_o = xval_i;
         fpu_pkg::OP_CSRRW:  result_o = {27'b0, flags_i};
         default: result_o = '0;
      endcase
   end

endmodule

`default_nettype wire

/* fpu_pipe.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_pipe
(
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 valid_i,
   input  wire logic                 stall_i,
   input  wire logic                 flush_i,
   input  wire fpu_pkg::fpu_instr_s  instr_i,
   output logic                      retire_valid_o,
   output fpu_pkg::fpu_retire_s      retire_o,
   output fpu_pkg::fflags_t          fflags_o
);

   fpu_pkg::fpu_instr_s  id_q;
   fpu_pkg::fpu_decode_s id_dec;
   fpu_pkg::fpu_exe_s    exe_q, exe;
   fpu_pkg::fpu_res_s    ex_res;
   fpu_pkg::fpu_res_s    mem_q, mem_res;
   fpu_pkg::fpu_res_s    wb_q, wb_res;
   fpu_pkg::fword_t      rf_rdata1, rf_rdata2;
   fpu_pkg::fword_t      fwd_a, op_a, op_b;
   fpu_pkg::fword_t      ex_result;
   fpu_pkg::fflags_t     ex_flags, pend_flags;
   logic                 adv;
   logic                 id_valid, exe_valid, mem_valid, wb_valid;
   logic [1:0]           fwd1_sel, fwd2_sel;

   function automatic fpu_pkg::fword_t fwd_pick(logic [1:0] sel, fpu_pkg::fword_t rf_val,
                                                fpu_pkg::fword_t mem_val,
                                                fpu_pkg::fword_t wb_val);
      case (sel)
         `FPU_FWD_MEM: return mem_val;
         `FPU_FWD_WB:  return wb_val;
         default:      return rf_val;
      endcase
   endfunction

   fpu_pipe_ctrl u_ctrl (
      .clk         (clk),
      .reset       (reset),
      .stall_i     (stall_i),
      .flush_i     (flush_i),
      .valid_i     (valid_i),
      .id_dec_i    (id_dec),
      .mem_res_i   (mem_res),
      .wb_res_i    (wb_res),
      .csr_wdata_i (op_a[4:0]),
      .adv_o       (adv),
      .id_valid_o  (id_valid),
      .exe_valid_o (exe_valid),
      .mem_valid_o (mem_valid),
      .wb_valid_o  (wb_valid),
      .fwd1_sel_o  (fwd1_sel),
      .fwd2_sel_o  (fwd2_sel),
      .fflags_o    (fflags_o)
   );

   ////////////////////////////////////////////////////////////////////////////
   // ID stage
   always_ff @(posedge clk)
   begin
      if (adv && valid_i)
         id_q <= instr_i;
   end

   fpu_decode u_decode (
      .instr_i (id_q.instr),
      .dec_o   (id_dec)
   );

   // WB writes at the edge it retires, ID sees it through the bypass
   fpu_regfile u_regfile (
      .clk      (clk),
      .reset    (reset),
      .we_i     (adv & wb_res.valid & wb_res.writes_frf),
      .waddr_i  (wb_res.rd),
      .wdata_i  (wb_res.result),
      .raddr1_i (id_dec.rs1),
      .raddr2_i (id_dec.rs2),
      .rdata1_o (rf_rdata1),
      .rdata2_o (rf_rdata2)
   );

   always_ff @(posedge clk)
   begin
      if (adv && id_valid)
         exe_q <= '{valid: id_valid,
                    dec:   id_dec,
                    a:     rf_rdata1,
                    b:     rf_rdata2,
                    xval:  id_q.xval};
   end

   // Stage records carry the valid bits owned by the control block
   always_comb
   begin
      exe           = exe_q;
      exe.valid     = exe_valid;
      mem_res       = mem_q;
      mem_res.valid = mem_valid;
      wb_res        = wb_q;
      wb_res.valid  = wb_valid;
   end

   ////////////////////////////////////////////////////////////////////////////
   // EXE stage
   assign fwd_a = fwd_pick(fwd1_sel, exe.a, mem_res.result, wb_res.result);
   assign op_a  = exe.dec.reads_frs1 ? fwd_a : exe.xval;
   assign op_b  = fwd_pick(fwd2_sel, exe.b, mem_res.result, wb_res.result);

   // Flags still in flight count as already raised for a CSR read
   assign pend_flags = fflags_o
                     | (mem_res.valid ? mem_res.flags : 5'b0)
                     | (wb_res.valid ? wb_res.flags : 5'b0);

   fpu_exec u_exec (
      .op_i     (exe.dec.op),
      .a_i      (op_a),
      .b_i      (op_b),
      .xval_i   (exe.xval),
      .flags_i  (pend_flags),
      .result_o (ex_result),
      .flags_o  (ex_flags)
   );

   assign ex_res = '{valid:      exe.valid,
                     rd:         exe.dec.rd,
                     writes_frf: exe.dec.writes_frf,
                     writes_int: exe.dec.writes_int,
                     result:     ex_result,
                     flags:      exe.dec.writes_fflags ? ex_flags : 5'b0};

   // MEM and WB result registers
   always_ff @(posedge clk)
   begin
      if (adv && exe.valid)
         mem_q <= ex_res;
      if (adv && mem_res.valid)
         wb_q <= mem_res;
   end

   assign retire_valid_o = adv & wb_res.valid;
   assign retire_o = '{rd:     wb_res.rd,
                       to_int: wb_res.writes_int,
                       data:   wb_res.result,
                       flags:  wb_res.flags};

endmodule

`default_nettype wire

/* fpu_pipe_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_pipe_ctrl
(
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire logic                  stall_i,
   input  wire logic                  flush_i,
   input  wire logic                  valid_i,
   input  wire fpu_pkg::fpu_decode_s  id_dec_i,
   input  wire fpu_pkg::fpu_res_s     mem_res_i,
   input  wire fpu_pkg::fpu_res_s     wb_res_i,
   input  wire fpu_pkg::fflags_t      csr_wdata_i,
   output logic                       adv_o,
   output logic                       id_valid_o,
   output logic                       exe_valid_o,
   output logic                       mem_valid_o,
   output logic                       wb_valid_o,
   output logic [1:0]                 fwd1_sel_o,
   output logic [1:0]                 fwd2_sel_o,
   output fpu_pkg::fflags_t           fflags_o
);

   fpu_pkg::freg_addr_t exe_rs1;
   fpu_pkg::freg_addr_t exe_rs2;
   logic                exe_rd1, exe_rd2;
   logic                exe_csr, mem_csr, wb_csr;
   fpu_pkg::fflags_t    mem_wdata, wb_wdata;

   // MEM result is the youngest, so it wins over WB
   function automatic logic [1:0] fwd_sel(fpu_pkg::freg_addr_t rs, logic rd_en,
                                          fpu_pkg::fpu_res_s mem, fpu_pkg::fpu_res_s wb);
      if (rd_en && mem.valid && mem.writes_frf && mem.rd == rs)
         return `FPU_FWD_MEM;
      if (rd_en && wb.valid && wb.writes_frf && wb.rd == rs)
         return `FPU_FWD_WB;
      return `FPU_FWD_RF;
   endfunction

   assign adv_o = ~stall_i;

   ////////////////////////////////////////////////////////////////////////////
   // Stage valid bits, flush drops whatever sits in ID and EXE
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         id_valid_o  <= 1'b0;
         exe_valid_o <= 1'b0;
         mem_valid_o <= 1'b0;
         wb_valid_o  <= 1'b0;
      end
      else if (adv_o)
      begin
         id_valid_o  <= valid_i & ~flush_i;
         exe_valid_o <= id_valid_o & ~flush_i;
         mem_valid_o <= exe_valid_o & ~flush_i;
         wb_valid_o  <= mem_valid_o;
      end
   end

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         exe_rd1 <= 1'b0;
         exe_rd2 <= 1'b0;
         exe_csr <= 1'b0;
         mem_csr <= 1'b0;
         wb_csr  <= 1'b0;
      end
      else if (adv_o)
      begin
         exe_rd1 <= id_dec_i.reads_frs1;
         exe_rd2 <= id_dec_i.reads_frs2;
         exe_csr <= id_dec_i.is_csr;
         mem_csr <= exe_csr;
         wb_csr  <= mem_csr;
      end
   end

   // Source addresses and the CSR write value follow their instruction
   always_ff @(posedge clk)
   begin
      if (adv_o)
      begin
         exe_rs1   <= id_dec_i.rs1;
         exe_rs2   <= id_dec_i.rs2;
         mem_wdata <= csr_wdata_i;
         wb_wdata  <= mem_wdata;
      end
   end

   assign fwd1_sel_o = fwd_sel(exe_rs1, exe_rd1, mem_res_i, wb_res_i);
   assign fwd2_sel_o = fwd_sel(exe_rs2, exe_rd2, mem_res_i, wb_res_i);

   ////////////////////////////////////////////////////////////////////////////
   // Sticky flags, committed as an instruction leaves WB
   always_ff @(posedge clk)
   begin
      if (reset)
         fflags_o <= '0;
      else if (adv_o && wb_valid_o)
      begin
         if (wb_csr)
            fflags_o <= wb_wdata;
         else
            fflags_o <= fflags_o | wb_res_i.flags;
      end
   end

endmodule

`default_nettype wire

/* fpu_pkg.sv */
`default_nettype none

`include "fpu_cfg.svh"

package fpu_pkg;

   typedef logic [`FPU_AW-1:0] freg_addr_t;
   typedef logic [`FPU_DW-1:0] fword_t;
   typedef logic [`FPU_DW-1:0] xword_t;

   // NV DZ OF UF NX, NV is the top bit
   typedef logic [4:0] fflags_t;

   typedef enum logic [3:0] {
      OP_NONE,
      OP_FSGNJ,
      OP_FSGNJN,
      OP_FSGNJX,
      OP_FMIN,
      OP_FMAX,
      OP_FEQ,
      OP_FLT,
      OP_FLE,
      OP_FCLASS,
      OP_FMVXW,
      OP_FMVWX,
      OP_FLW,
      OP_CSRRW
   } fpu_op_e;

   // Instruction as handed over by the integer side
   typedef struct packed {
      logic [31:0] instr;
      xword_t      xval;
   } fpu_instr_s;

   typedef struct packed {
      fpu_op_e    op;
      freg_addr_t rs1;
      freg_addr_t rs2;
      freg_addr_t rd;
      logic       reads_frs1;
      logic       reads_frs2;
      logic       writes_frf;
      logic       writes_int;
      logic       writes_fflags;
      logic       is_csr;
   } fpu_decode_s;

   typedef struct packed {
      logic        valid;
      fpu_decode_s dec;
      fword_t      a;
      fword_t      b;
      xword_t      xval;
   } fpu_exe_s;

   typedef struct packed {
      logic       valid;
      freg_addr_t rd;
      logic       writes_frf;
      logic       writes_int;
      fword_t     result;
      fflags_t    flags;
   } fpu_res_s;

   typedef struct packed {
      freg_addr_t rd;
      logic       to_int;
      xword_t     data;
      fflags_t    flags;
   } fpu_retire_s;

endpackage

`default_nettype wire

/* fpu_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

`include "fpu_cfg.svh"

module fpu_regfile
(
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 we_i,
   input  wire fpu_pkg::freg_addr_t  waddr_i,
   input  wire fpu_pkg::fword_t      wdata_i,
   input  wire fpu_pkg::freg_addr_t  raddr1_i,
   input  wire fpu_pkg::freg_addr_t  raddr2_i,
   output fpu_pkg::fword_t           rdata1_o,
   output fpu_pkg::fword_t           rdata2_o
);

   fpu_pkg::fword_t regs [`FPU_NREGS];

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         for (int i = 0; i < `FPU_NREGS; i++)
            regs[i] <= '0;
      end
      else if (we_i)
         regs[waddr_i] <= wdata_i;
   end

   // A write in flight shows through to a reader of the same entry
   always_comb
   begin
      rdata1_o = regs[raddr1_i];
      if (we_i && waddr_i == raddr1_i)
         rdata1_o = wdata_i;
      rdata2_o = regs[raddr2_i];
      if (we_i && waddr_i == raddr2_i)
         rdata2_o = wdata_i;
   end

endmodule

`default_nettype wire

/* fpu_stim.txt */
// kind_instr_xval_rd_toint_data_flags in hex; kind 1 issue and retire, 2 issue then flushed,
// 3 stall for xval cycles, 4 flush, 5 drain and check fflags, 6 idle for xval cycles
// Loads and moves into f1 to f10
1_00002087_3F800000_01_0_3F800000_00
1_00002107_C0000000_02_0_C0000000_00
1_00002187_80000000_03_0_80000000_00
1_00002207_00000000_04_0_00000000_00
1_00002287_7F800000_05_0_7F800000_00
1_00002307_80000001_06_0_80000001_00
1_00002387_7FC00000_07_0_7FC00000_00
1_00002407_7F800001_08_0_7F800001_00
1_F00504D3_FF800000_09_0_FF800000_00
1_F0050553_00400000_0A_0_00400000_00
6_00000000_00000004_00_0_00000000_00
1_E00082D3_00000000_05_1_3F800000_00
// Sign injection, then FCLASS over every class
1_202085D3_00000000_0B_0_BF800000_00
1_20211653_00000000_0C_0_40000000_00
1_202426D3_00000000_0D_0_FF800001_00
1_E00092D3_00000000_05_1_00000040_00
1_E00112D3_00000000_05_1_00000002_00
1_E00192D3_00000000_05_1_00000008_00
1_E00212D3_00000000_05_1_00000010_00
1_E00292D3_00000000_05_1_00000080_00
1_E00312D3_00000000_05_1_00000004_00
1_E00392D3_00000000_05_1_00000200_00
1_E00412D3_00000000_05_1_00000100_00
1_E00492D3_00000000_05_1_00000001_00
1_E00512D3_00000000_05_1_00000020_00
// Dependent pairs at distance 1, 2 and 3
1_F0050753_92345678_0E_0_92345678_00
1_E00702D3_00000000_05_1_92345678_00
1_F00507D3_CAFEF00D_0F_0_CAFEF00D_00
6_00000000_00000001_00_0_00000000_00
1_20F08853_00000000_10_0_BF800000_00
1_E00802D3_00000000_05_1_BF800000_00
1_F00508D3_01020304_11_0_01020304_00
6_00000000_00000002_00_0_00000000_00
1_E00882D3_00000000_05_1_01020304_00
// Min, max and compares with signed zero and NaN, then fflags through CSRRW
1_28418953_00000000_12_0_80000000_00
1_284199D3_00000000_13_0_00000000_00
1_28138A53_00000000_14_0_3F800000_00
1_A013A2D3_00000000_05_1_00000000_00
1_A04182D3_00000000_05_1_00000001_00
1_A04192D3_00000000_05_1_00000000_00
1_A01112D3_00000000_05_1_00000001_00
5_00000000_00000000_00_0_00000000_00
1_A01392D3_00000000_05_1_00000000_10
1_001512F3_00000003_05_1_00000010_00
5_00000000_00000000_00_0_00000000_03
1_28141AD3_00000000_15_0_3F800000_10
1_A01422D3_00000000_05_1_00000000_10
1_28838B53_00000000_16_0_7FC00000_10
5_00000000_00000000_00_0_00000000_13
1_001512F3_00000000_05_1_00000013_00
5_00000000_00000000_00_0_00000000_00
// Stall burst, then a flush that drops the two youngest writes
1_E00082D3_00000000_05_1_3F800000_00
3_00000000_00000005_00_0_00000000_00
1_E00102D3_00000000_05_1_C0000000_00
1_F0050753_55555555_0E_0_55555555_00
2_F00508D3_DEADBEEF_00_0_00000000_00
2_F00507D3_DEADBEEF_00_0_00000000_00
4_00000000_00000000_00_0_00000000_00
1_E00882D3_00000000_05_1_01020304_00
1_E00782D3_00000000_05_1_CAFEF00D_00
1_E00702D3_00000000_05_1_55555555_00
5_00000000_00000000_00_0_00000000_00

/* fpu_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module fpu_tb;

   localparam int STIM_DEPTH  = 128;
   localparam int DRAIN_LIMIT = 40;

   // One line of the stimulus file with fields as written in hex
   typedef struct packed {
      logic [3:0]  kind;
      logic [31:0] instr;
      logic [31:0] xval;
      logic [7:0]  rd;
      logic [3:0]  to_int;
      logic [31:0] data;
      logic [7:0]  flags;
   } stim_line_s;

   // Expected retire plus the issue cycle and stall count at issue
   typedef struct packed {
      fpu_pkg::fpu_retire_s rec;
      int                   cyc;
      int                   stalls;
   } pend_s;

   logic                 clk;
   logic                 reset;
   logic                 valid_i;
   logic                 stall_i;
   logic                 flush_i;
   fpu_pkg::fpu_instr_s  instr_i;
   logic                 retire_valid_o;
   fpu_pkg::fpu_retire_s retire_o;
   fpu_pkg::fflags_t     fflags_o;

   logic [119:0] stim_mem [STIM_DEPTH];
   stim_line_s   line;
   pend_s        pend;
   pend_s        exp_q [$];
   integer       seed;
   int           cyc;
   int           stall_cnt;
   int           idx;

   fpu_pipe DUT (
      .clk            (clk),
      .reset          (reset),
      .valid_i        (valid_i),
      .stall_i        (stall_i),
      .flush_i        (flush_i),
      .instr_i        (instr_i),
      .retire_valid_o (retire_valid_o),
      .retire_o       (retire_o),
      .fflags_o       (fflags_o)
   );

   always #10 clk = ~clk;

   always @(posedge clk)
   begin
      cyc <= cyc + 1;
      if (stall_i)
         stall_cnt <= stall_cnt + 1;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks

   task automatic abort_run();
      $display("Simulation failed");
      $fatal(1);
   endtask

   task automatic check_retire(input fpu_pkg::fpu_retire_s got,
                               input fpu_pkg::fpu_retire_s exp);
      if (got !== exp)
      begin
         $display("[ERROR] retire_o got rd=%h to_int=%h data=%h flags=%h",
                  got.rd, got.to_int, got.data, got.flags);
         $display("        expected rd=%h to_int=%h data=%h flags=%h",
                  exp.rd, exp.to_int, exp.data, exp.flags);
         abort_run();
      end
   endtask

   task automatic check_flags(input fpu_pkg::fflags_t got, input fpu_pkg::fflags_t exp);
      if (got !== exp)
      begin
         $display("[ERROR] fflags_o got %h expected %h", got, exp);
         abort_run();
      end
   endtask

   // Retires are sampled mid-cycle where stall_i and the outputs have settled
   always @(negedge clk)
   begin
      pend_s head;
      int    lat;
      int    want;
      if (!reset && retire_valid_o === 1'b1)
      begin
         if (exp_q.size() == 0)
         begin
            $display("A retire appeared while no instruction was outstanding");
            abort_run();
         end
         head = exp_q.pop_front();
         check_retire(retire_o, head.rec);
         // Acceptance is one edge after the drive cycle
         lat  = cyc - head.cyc - 1;
         want = 3 + (stall_cnt - head.stalls);
         if (lat != want)
         begin
            $display("Instruction retired %0d cycles after issue instead of %0d", lat, want);
            abort_run();
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Driver

   task automatic drive(input logic v, input logic s, input logic f,
                        input logic [31:0] word, input logic [31:0] xv);
      valid_i       = v;
      stall_i       = s;
      flush_i       = f;
      instr_i.instr = word;
      instr_i.xval  = xv;
      @(posedge clk);
      #2;
   endtask

   task automatic insert_random_stall();
      int n;
      n = 0;
      if (($random(seed) & 3) == 0)
         n = 1 + ($random(seed) & 3);
      repeat (n) drive(1'b0, 1'b1, 1'b0, '0, '0);
   endtask

   // Idles until every expected retire is seen, then lets the last flags commit
   task automatic drain_pipe();
      int waited;
      waited = 0;
      while (exp_q.size() != 0)
      begin
         if (waited == DRAIN_LIMIT)
         begin
            $display("Timed out waiting for %0d outstanding retires", exp_q.size());
            abort_run();
         end
         drive(1'b0, 1'b0, 1'b0, '0, '0);
         waited++;
      end
      drive(1'b0, 1'b0, 1'b0, '0, '0);
   endtask

   initial
   begin
      seed      = 32'had66;
      clk       = 1'b0;
      reset     = 1'b1;
      valid_i   = 1'b0;
      stall_i   = 1'b0;
      flush_i   = 1'b0;
      instr_i   = '0;
      cyc       = 0;
      stall_cnt = 0;
      for (int i = 0; i < STIM_DEPTH; i++)
         stim_mem[i] = '0;
      $readmemh("fpu_stim.txt", stim_mem);
      line = stim_mem[0];
      if (line.kind == 4'h0)
      begin
         $display("The stimulus file is missing or holds no lines");
         abort_run();
      end

      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;

      idx = 0;
      while (idx < STIM_DEPTH && line.kind != 4'h0)
      begin
         case (line.kind)
            4'h1, 4'h2:
            begin
               insert_random_stall();
               // Kind 2 is removed by a later flush and never retires
               if (line.kind == 4'h1)
               begin
                  pend.rec.rd     = line.rd[4:0];
                  pend.rec.to_int = line.to_int[0];
                  pend.rec.data   = line.data;
                  pend.rec.flags  = line.flags[4:0];
                  pend.cyc        = cyc;
                  pend.stalls     = stall_cnt;
                  exp_q.push_back(pend);
               end
               drive(1'b1, 1'b0, 1'b0, line.instr, line.xval);
            end
            4'h3: repeat (line.xval) drive(1'b0, 1'b1, 1'b0, '0, '0);
            4'h4: drive(1'b0, 1'b0, 1'b1, '0, '0);
            4'h5:
            begin
               drain_pipe();
               check_flags(fflags_o, line.flags[4:0]);
            end
            4'h6: repeat (line.xval) drive(1'b0, 1'b0, 1'b0, '0, '0);
            default:
            begin
               $display("Stimulus line %0d has an unknown kind %0h", idx, line.kind);
               abort_run();
            end
         endcase
         idx++;
         if (idx < STIM_DEPTH)
            line = stim_mem[idx];
      end

      drain_pipe();
      repeat (6) drive(1'b0, 1'b0, 1'b0, '0, '0);
      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

/* src.f */
+incdir+.
fpu_pkg.sv
fpu_decode.sv
fpu_regfile.sv
fpu_exec.sv
fpu_pipe_ctrl.sv
fpu_pipe.sv
fpu_tb.sv
